// File: src/fe_pkg.sv
// Shared widths, enums and message structs for the fetch front end.
// Imported by every RTL module and by the testbench.

package fe_pkg;

  localparam int vaddr_width   = 32;
  localparam int instr_width   = 32;
  // index sits just above the two byte-offset bits, tag just above the index
  localparam int btb_idx_width = 6;
  localparam int btb_tag_width = 8;

  typedef enum logic
  {
    cmd_reset,
    cmd_redirect
  } fe_cmd_op_e;

  // backend to front end
  typedef struct packed
  {
    fe_cmd_op_e               op;
    logic [vaddr_width-1:0]   pc;
    logic [btb_tag_width-1:0] btb_tag;
    logic [btb_idx_width-1:0] btb_idx;
  } fe_cmd_s;

  typedef enum logic [1:0]
  {
    scan_branch,
    scan_jal,
    scan_other
  } fe_scan_class_e;

  // class is a keyword, hence instr_class
  typedef struct packed
  {
    fe_scan_class_e         instr_class;
    logic [vaddr_width-1:0] imm;
  } fe_scan_s;

  typedef struct packed
  {
    logic [vaddr_width-1:0] addr;
    logic [instr_width-1:0] instr;
  } fe_icache_resp_s;

  typedef enum logic
  {
    msg_fetch,
    msg_exception
  } fe_msg_type_e;

  typedef enum logic [1:0]
  {
    exc_misaligned
  } fe_exc_code_e;

  // front end to backend
  typedef struct packed
  {
    fe_msg_type_e             msg_type;
    logic [vaddr_width-1:0]   pc;
    logic [instr_width-1:0]   instr;
    logic [btb_tag_width-1:0] btb_tag;
    logic [btb_idx_width-1:0] btb_idx;
    fe_exc_code_e             exc_code;
  } fe_queue_s;

endpackage

// File: src/fe_instr_scan.sv
// Combinational predecode of one RV32 instruction.
// Classifies branch / jal and returns the sign-extended target offset.

module fe_instr_scan
  (input  logic [fe_pkg::instr_width-1:0] instr_i
  , output fe_pkg::fe_scan_s              scan_o
  );

  import fe_pkg::*;

  // major opcodes that matter for prediction
  typedef enum logic [6:0]
  {
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } rv_opcode_e;

  logic [12:0] imm_b;
  logic [20:0] imm_j;

  // B-type and J-type immediate bit scrambles
  assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb
  begin
    case (instr_i[6:0])
      op_branch:
      begin
        scan_o.instr_class = scan_branch;
        scan_o.imm         = {{(vaddr_width-13){imm_b[12]}}, imm_b};
      end
      op_jal:
      begin
        scan_o.instr_class = scan_jal;
        scan_o.imm         = {{(vaddr_width-21){imm_j[20]}}, imm_j};
      end
      default:
      begin
        scan_o.instr_class = scan_other;
        scan_o.imm         = '0;
      end
    endcase
  end

endmodule

// File: src/fe_btb.sv
// Direct-mapped branch target buffer.
// Read address is registered, so hit and target appear one cycle after r_v_i.
// Entries are written by redirect commands; a same-cycle read sees old data.

module fe_btb
  (input  logic                              clk_i
  , input  logic                             reset_i
  , input  logic [fe_pkg::vaddr_width-1:0]   r_addr_i
  , input  logic                             r_v_i
  , output logic [fe_pkg::vaddr_width-1:0]   tgt_o
  , output logic                             tgt_v_o
  , input  logic                             w_v_i
  , input  logic [fe_pkg::btb_idx_width-1:0] w_idx_i
  , input  logic [fe_pkg::btb_tag_width-1:0] w_tag_i
  , input  logic [fe_pkg::vaddr_width-1:0]   w_tgt_i
  );

  import fe_pkg::*;

  localparam int entries = 2 ** btb_idx_width;

  typedef struct packed
  {
    logic [btb_tag_width-1:0] tag;
    logic [vaddr_width-1:0]   tgt;
  } btb_entry_s;

  btb_entry_s               mem [entries];
  logic [entries-1:0]       valid_q;
  logic [btb_idx_width-1:0] r_idx;
  logic [btb_tag_width-1:0] r_tag;
  btb_entry_s               rd_entry_q;
  logic [btb_tag_width-1:0] rd_tag_q;
  logic                     rd_v_q;

  assign r_idx = r_addr_i[2 +: btb_idx_width];
  assign r_tag = r_addr_i[2+btb_idx_width +: btb_tag_width];

  // valid bits and read strobe
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_q <= '0;
      rd_v_q  <= 1'b0;
    end
    else
    begin
      rd_v_q <= r_v_i & valid_q[r_idx];
      if (w_v_i)
        valid_q[w_idx_i] <= 1'b1;
    end
  end

  // storage and registered read
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
      mem[w_idx_i] <= '{tag: w_tag_i, tgt: w_tgt_i};
    if (r_v_i)
    begin
      rd_entry_q <= mem[r_idx];
      rd_tag_q   <= r_tag;
    end
  end

  assign tgt_o   = rd_entry_q.tgt;
  assign tgt_v_o = rd_v_q & (rd_entry_q.tag == rd_tag_q);

endmodule

// File: src/fe_pc_gen.sv
// Next-pc generation, fetch stage and one-entry output queue.
// Commands restart the stream; misses and back-pressure replay the lost pc.
// Prediction: btb hit, then backward branch / jal, then pc+4.

module fe_pc_gen
  (input  logic                              clk_i
  , input  logic                             reset_i
  , input  fe_pkg::fe_cmd_s                  fe_cmd_i
  , input  logic                             fe_cmd_v_i
  , output logic [fe_pkg::vaddr_width-1:0]   icache_req_o
  , output logic                             icache_req_v_o
  , input  logic                             icache_ready_i
  , input  fe_pkg::fe_icache_resp_s          icache_resp_i
  , input  logic                             icache_resp_v_i
  , input  logic                             icache_miss_i
  , input  fe_pkg::fe_scan_s                 scan_i
  , output logic [fe_pkg::vaddr_width-1:0]   btb_r_addr_o
  , output logic                             btb_r_v_o
  , input  logic [fe_pkg::vaddr_width-1:0]   btb_tgt_i
  , input  logic                             btb_tgt_v_i
  , output logic                             btb_w_v_o
  , output logic [fe_pkg::btb_idx_width-1:0] btb_w_idx_o
  , output logic [fe_pkg::btb_tag_width-1:0] btb_w_tag_o
  , output logic [fe_pkg::vaddr_width-1:0]   btb_w_tgt_o
  , output fe_pkg::fe_queue_s                fe_queue_o
  , output logic                             fe_queue_v_o
  , input  logic                             fe_queue_ready_i
  );

  import fe_pkg::*;

  typedef enum logic [1:0]
  {
    boot,
    run,
    halt
  } state_e;

  state_e                 state_q;
  state_e                 state_n;
  logic                   fetch_v_q;
  logic [vaddr_width-1:0] fetch_pc_q;
  logic [vaddr_width-1:0] pending_pc_q;
  logic [vaddr_width-1:0] pc_n;
  logic [vaddr_width-1:0] resp_pc;
  logic [vaddr_width-1:0] msg_pc;
  fe_queue_s              queue_q;
  fe_queue_s              queue_n;
  logic                   queue_v_q;
  logic                   cmd_misaligned;
  logic                   stall;
  logic                   fetch_hit;
  logic                   predict_taken;
  logic                   req_accept;
  logic                   load_queue;

  assign cmd_misaligned = fe_cmd_i.pc[1:0] != 2'b00;
  // full queue that is not draining freezes the front end
  assign stall          = queue_v_q & ~fe_queue_ready_i;
  // usable response with data back, room to queue it and no flush
  assign fetch_hit      = fetch_v_q & icache_resp_v_i & ~icache_miss_i & ~stall & ~fe_cmd_v_i;
  assign resp_pc        = icache_resp_i.addr;
  assign predict_taken  = (scan_i.instr_class == scan_jal)
                        | ((scan_i.instr_class == scan_branch) & scan_i.imm[vaddr_width-1]);

  always_comb
  begin
    if (fe_cmd_v_i)
      pc_n = fe_cmd_i.pc;
    // response lost to a miss or a frozen queue is fetched again
    else if (fetch_v_q & ~fetch_hit)
      pc_n = fetch_pc_q;
    else if (fetch_hit & btb_tgt_v_i)
      pc_n = btb_tgt_i;
    else if (fetch_hit & predict_taken)
      pc_n = resp_pc + scan_i.imm;
    else if (fetch_hit)
      pc_n = resp_pc + vaddr_width'(4);
    else
      pc_n = pending_pc_q;
  end

  // a command issues in its own cycle, even from boot or halt
  assign icache_req_o   = pc_n;
  assign icache_req_v_o = fe_cmd_v_i ? ~cmd_misaligned : ((state_q == run) & ~stall);
  assign req_accept     = icache_req_v_o & icache_ready_i;

  assign btb_r_addr_o = pc_n;
  assign btb_r_v_o    = req_accept;

  assign btb_w_v_o   = fe_cmd_v_i & (fe_cmd_i.op == cmd_redirect) & ~cmd_misaligned;
  assign btb_w_idx_o = fe_cmd_i.btb_idx;
  assign btb_w_tag_o = fe_cmd_i.btb_tag;
  assign btb_w_tgt_o = fe_cmd_i.pc;

  assign state_n = fe_cmd_v_i ? (cmd_misaligned ? halt : run) : state_q;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q   <= boot;
      fetch_v_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_n;
      fetch_v_q <= req_accept;
    end
  end

  // fetch pc follows accepted requests, pending pc holds the rest
  always_ff @(posedge clk_i)
  begin
    if (req_accept)
      fetch_pc_q <= pc_n;
    else
      pending_pc_q <= pc_n;
  end

  // a command here can only load an exception message
  assign load_queue = fe_cmd_v_i ? cmd_misaligned : fetch_hit;
  assign msg_pc     = fe_cmd_v_i ? fe_cmd_i.pc : resp_pc;

  always_comb
  begin
    queue_n.msg_type = fe_cmd_v_i ? msg_exception : msg_fetch;
    queue_n.pc       = msg_pc;
    queue_n.instr    = fe_cmd_v_i ? '0 : icache_resp_i.instr;
    queue_n.btb_tag  = msg_pc[2+btb_idx_width +: btb_tag_width];
    queue_n.btb_idx  = msg_pc[2 +: btb_idx_width];
    queue_n.exc_code = exc_misaligned;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      queue_v_q <= 1'b0;
    else if (fe_cmd_v_i | fetch_hit)
      queue_v_q <= load_queue;
    else if (fe_queue_ready_i)
      queue_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (load_queue)
      queue_q <= queue_n;
  end

  assign fe_queue_o   = queue_q;
  assign fe_queue_v_o = queue_v_q;

endmodule

// File: src/fe_top.sv
// Fetch front end top level.
// Ties pc generation to the btb and predecoder; cache and backend ports go out.

module fe_top
  (input  logic                            clk_i
  , input  logic                           reset_i
  , input  fe_pkg::fe_cmd_s                fe_cmd_i
  , input  logic                           fe_cmd_v_i
  , output logic [fe_pkg::vaddr_width-1:0] icache_req_o
  , output logic                           icache_req_v_o
  , input  logic                           icache_ready_i
  , input  fe_pkg::fe_icache_resp_s        icache_resp_i
  , input  logic                           icache_resp_v_i
  , input  logic                           icache_miss_i
  , output fe_pkg::fe_queue_s              fe_queue_o
  , output logic                           fe_queue_v_o
  , input  logic                           fe_queue_ready_i
  );

  import fe_pkg::*;

  fe_scan_s                 scan;
  logic [vaddr_width-1:0]   btb_r_addr;
  logic                     btb_r_v;
  logic [vaddr_width-1:0]   btb_tgt;
  logic                     btb_tgt_v;
  logic                     btb_w_v;
  logic [btb_idx_width-1:0] btb_w_idx;
  logic [btb_tag_width-1:0] btb_w_tag;
  logic [vaddr_width-1:0]   btb_w_tgt;

  fe_pc_gen pc_gen_inst
    (.clk_i            (clk_i)
    , .reset_i         (reset_i)
    , .fe_cmd_i        (fe_cmd_i)
    , .fe_cmd_v_i      (fe_cmd_v_i)
    , .icache_req_o    (icache_req_o)
    , .icache_req_v_o  (icache_req_v_o)
    , .icache_ready_i  (icache_ready_i)
    , .icache_resp_i   (icache_resp_i)
    , .icache_resp_v_i (icache_resp_v_i)
    , .icache_miss_i   (icache_miss_i)
    , .scan_i          (scan)
    , .btb_r_addr_o    (btb_r_addr)
    , .btb_r_v_o       (btb_r_v)
    , .btb_tgt_i       (btb_tgt)
    , .btb_tgt_v_i     (btb_tgt_v)
    , .btb_w_v_o       (btb_w_v)
    , .btb_w_idx_o     (btb_w_idx)
    , .btb_w_tag_o     (btb_w_tag)
    , .btb_w_tgt_o     (btb_w_tgt)
    , .fe_queue_o      (fe_queue_o)
    , .fe_queue_v_o    (fe_queue_v_o)
    , .fe_queue_ready_i(fe_queue_ready_i)
    );

  fe_btb btb_inst
    (.clk_i     (clk_i)
    , .reset_i  (reset_i)
    , .r_addr_i (btb_r_addr)
    , .r_v_i    (btb_r_v)
    , .tgt_o    (btb_tgt)
    , .tgt_v_o  (btb_tgt_v)
    , .w_v_i    (btb_w_v)
    , .w_idx_i  (btb_w_idx)
    , .w_tag_i  (btb_w_tag)
    , .w_tgt_i  (btb_w_tgt)
    );

  // predecode the instruction coming back from the cache
  fe_instr_scan scan_inst
    (.instr_i (icache_resp_i.instr)
    , .scan_o (scan)
    );

endmodule

// File: sim/fe_tb.sv
// Testbench for the fetch front end with random cache, queue and command traffic.
// Every queue transfer is checked against a reference model of the predicted stream.
// Compile with vlog.f; the top module is fe_tb.

module fe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fe_pkg::*;

  localparam int run_cycles  = 3000;
  localparam int watchdog_ns = (run_cycles + 600) * 4 + 400;
  localparam logic [vaddr_width-1:0] boot_pc = 32'h0000_0100;

  typedef enum int {m_boot, m_run, m_exc, m_halt} model_mode_e;
  typedef enum int {k_other, k_bwd, k_fwd, k_jal} word_kind_e;

  logic                   clk_i = 1'b0;
  logic                   reset_i;
  fe_cmd_s                fe_cmd_i;
  logic                   fe_cmd_v_i;
  logic [vaddr_width-1:0] icache_req_o;
  logic                   icache_req_v_o;
  logic                   icache_ready_i;
  fe_icache_resp_s        icache_resp_i;
  logic                   icache_resp_v_i;
  logic                   icache_miss_i;
  fe_queue_s              fe_queue_o;
  logic                   fe_queue_v_o;
  logic                   fe_queue_ready_i;

  // instruction table and what each word does to the pc
  logic [instr_width-1:0] imem [64];
  word_kind_e             kind_tab [64];
  int                     off_tab [64];

  // reference model state
  model_mode_e              mode;
  logic [vaddr_width-1:0]   exp_pc;
  logic                     first_msg;
  logic                     first_old;
  logic                     after_cmd;
  logic                     old_hit;
  logic [vaddr_width-1:0]   old_tgt;
  logic                     mbtb_v [64];
  logic [btb_tag_width-1:0] mbtb_tag [64];
  logic [vaddr_width-1:0]   mbtb_tgt [64];
  logic                     acc_q;
  logic [vaddr_width-1:0]   acc_addr;

  int seed;
  int errors      = 0;
  int flow_errors = 0;
  int n_checks    = 0;
  int n_msgs      = 0;
  int n_btb_pred  = 0;
  int n_taken     = 0;
  int n_exc       = 0;
  int n_miss      = 0;

  fe_top fe_top_inst
    (.clk_i            (clk_i)
    , .reset_i         (reset_i)
    , .fe_cmd_i        (fe_cmd_i)
    , .fe_cmd_v_i      (fe_cmd_v_i)
    , .icache_req_o    (icache_req_o)
    , .icache_req_v_o  (icache_req_v_o)
    , .icache_ready_i  (icache_ready_i)
    , .icache_resp_i   (icache_resp_i)
    , .icache_resp_v_i (icache_resp_v_i)
    , .icache_miss_i   (icache_miss_i)
    , .fe_queue_o      (fe_queue_o)
    , .fe_queue_v_o    (fe_queue_v_o)
    , .fe_queue_ready_i(fe_queue_ready_i)
    );

  always #2 clk_i = ~clk_i;

  function automatic int rnd(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // 1/8 backward branch, 1/16 jal, 1/16 forward branch, rest plain ops
  task automatic fill_table();
    int          r;
    int          off;
    logic [31:0] r32;
    logic [12:0] imm_b;
    logic [20:0] imm_j;
    for (int i = 0; i < 64; i++)
    begin
      r   = rnd(16);
      r32 = $random(seed);
      off = 0;
      kind_tab[i] = k_other;
      imem[i]     = {r32[31:7], 7'b0010011};
      if (r < 3)
      begin
        off   = (r == 2) ? 4 * (1 + rnd(8)) : -4 * (1 + rnd(8));
        imm_b = 13'(off);
        kind_tab[i] = (r == 2) ? k_fwd : k_bwd;
        imem[i] = {imm_b[12], imm_b[10:5], r32[24:15], 3'b000, imm_b[4:1], imm_b[11],
                   7'b1100011};
      end
      else if (r == 3)
      begin
        off   = (rnd(2) == 0) ? 4 * (1 + rnd(16)) : -4 * (1 + rnd(16));
        imm_j = 21'(off);
        kind_tab[i] = k_jal;
        imem[i] = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], r32[11:7], 7'b1101111};
      end
      off_tab[i] = off;
    end
  endtask

  function automatic logic btb_hit(input logic [vaddr_width-1:0] pc);
    logic [btb_idx_width-1:0] idx;
    idx = pc[2 +: btb_idx_width];
    return mbtb_v[idx] && (mbtb_tag[idx] == pc[2+btb_idx_width +: btb_tag_width]);
  endfunction

  function automatic logic [vaddr_width-1:0] btb_target(input logic [vaddr_width-1:0] pc);
    return mbtb_tgt[pc[2 +: btb_idx_width]];
  endfunction

  // static rule: backward branch and jal taken, otherwise fall through
  function automatic logic [vaddr_width-1:0] static_next(input logic [vaddr_width-1:0] pc);
    if (kind_tab[pc[7:2]] == k_bwd || kind_tab[pc[7:2]] == k_jal)
      return pc + 32'(off_tab[pc[7:2]]);
    return pc + 4;
  endfunction

  task automatic report_problem(input string what);
    $display("ERROR: %s (at %0t ns)", what, $time);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    n_checks++;
    assert (got === want)
    else
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h (at %0t ns)", name, got, want, $time);
      errors++;
    end
  endtask

  task automatic check_message();
    logic                   hit;
    logic [vaddr_width-1:0] tgt;
    logic [vaddr_width-1:0] next_pc;
    n_msgs++;
    assert (mode == m_run || mode == m_exc)
    else report_problem("a message was transferred while the front end should be idle");
    if (mode == m_exc)
    begin
      check_value("fe_queue_o.msg_type", 32'(fe_queue_o.msg_type), 32'(msg_exception));
      check_value("fe_queue_o.pc", fe_queue_o.pc, exp_pc);
      check_value("fe_queue_o.instr", fe_queue_o.instr, 32'h0);
      check_value("fe_queue_o.exc_code", 32'(fe_queue_o.exc_code), 32'(exc_misaligned));
      n_exc++;
      mode = m_halt;
    end
    else if (mode == m_run)
    begin
      check_value("fe_queue_o.msg_type", 32'(fe_queue_o.msg_type), 32'(msg_fetch));
      check_value("fe_queue_o.pc", fe_queue_o.pc, exp_pc);
      check_value("fe_queue_o.instr", fe_queue_o.instr, imem[exp_pc[7:2]]);
      check_value("fe_queue_o.btb_idx", 32'(fe_queue_o.btb_idx),
                  32'(exp_pc[2 +: btb_idx_width]));
      check_value("fe_queue_o.btb_tag", 32'(fe_queue_o.btb_tag),
                  32'(exp_pc[2+btb_idx_width +: btb_tag_width]));
      // first pc may have been looked up before the command's own write
      hit = (first_msg && first_old) ? old_hit : btb_hit(exp_pc);
      tgt = (first_msg && first_old) ? old_tgt : btb_target(exp_pc);
      if (hit)
      begin
        next_pc = tgt;
        n_btb_pred++;
      end
      else
      begin
        next_pc = static_next(exp_pc);
        if (next_pc != exp_pc + 4)
          n_taken++;
      end
      first_msg = 1'b0;
      exp_pc    = next_pc;
    end
  endtask

  task automatic apply_command();
    logic [btb_idx_width-1:0] idx;
    idx    = fe_cmd_i.btb_idx;
    exp_pc = fe_cmd_i.pc;
    if (fe_cmd_i.pc[1:0] != 2'b00)
      mode = m_exc;
    else
    begin
      mode      = m_run;
      first_msg = 1'b1;
      first_old = 1'b0;
      after_cmd = 1'b1;
      old_hit   = btb_hit(exp_pc);
      old_tgt   = btb_target(exp_pc);
      if (fe_cmd_i.op == cmd_redirect)
      begin
        mbtb_v[idx]   = 1'b1;
        mbtb_tag[idx] = fe_cmd_i.btb_tag;
        mbtb_tgt[idx] = fe_cmd_i.pc;
      end
    end
  endtask

  // model runs mid-cycle where all inputs and outputs are settled
  always @(negedge clk_i)
  begin : model
    if (reset_i)
    begin
      mode      = m_boot;
      acc_q     = 1'b0;
      after_cmd = 1'b0;
      for (int i = 0; i < 64; i++)
        mbtb_v[i] = 1'b0;
    end
    else
    begin
      if (mode == m_boot)
      begin
        assert (!fe_queue_v_o)
        else report_problem("queue valid before the reset command");
      end
      if (mode != m_run)
      begin
        assert (fe_cmd_v_i || !icache_req_v_o)
        else report_problem("cache request made while the front end is idle");
      end
      if (fe_queue_v_o && fe_queue_ready_i)
        check_message();
      if (after_cmd)
      begin
        // data for the command pc came back, so its btb read predates the write
        first_old = icache_resp_v_i & ~fe_cmd_v_i;
        after_cmd = 1'b0;
      end
      acc_q    = icache_req_v_o & icache_ready_i;
      acc_addr = icache_req_o;
      if (fe_cmd_v_i)
        apply_command();
    end
  end

  // one cycle of stimulus where the cache answers last cycle's request
  task automatic drive_cycle(input logic send, input fe_cmd_s c);
    @(posedge clk_i);
    #1;
    fe_cmd_v_i       = send;
    fe_cmd_i         = c;
    icache_ready_i   = (rnd(4) != 0);
    fe_queue_ready_i = (rnd(4) != 0);
    icache_resp_v_i  = 1'b0;
    icache_miss_i    = 1'b0;
    if (acc_q)
    begin
      if (rnd(6) == 0)
      begin
        icache_miss_i = 1'b1;
        n_miss++;
      end
      else
      begin
        icache_resp_v_i     = 1'b1;
        icache_resp_i.addr  = acc_addr;
        icache_resp_i.instr = imem[acc_addr[7:2]];
      end
    end
  endtask

  // pcs stay low so that random btb tags meet fetched pcs
  function automatic fe_cmd_s random_redirect();
    fe_cmd_s c;
    c.op = cmd_redirect;
    c.pc = 32'h100 + 32'(rnd(192)) * 4;
    if (rnd(5) == 0)
      c.pc[1:0] = 2'(1 + rnd(3));
    c.btb_idx = 6'(rnd(64));
    c.btb_tag = 8'(1 + rnd(3));
    return c;
  endfunction

  function automatic fe_cmd_s make_cmd(input fe_cmd_op_e op, input logic [31:0] pc,
                                       input int idx, input int tag);
    fe_cmd_s c;
    c.op      = op;
    c.pc      = pc;
    c.btb_idx = 6'(idx);
    c.btb_tag = 8'(tag);
    return c;
  endfunction

  task automatic end_test(input string name, input int err_start);
    @(negedge clk_i);
    #1;
    $display("test %-10s done, %0d errors", name, errors + flow_errors - err_start);
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the tests did not finish in the expected time");
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    int gap;
    int err_start;
    int btb_start;
    int exc_start;
    seed             = 56;
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    icache_ready_i   = 1'b0;
    icache_resp_i    = '0;
    icache_resp_v_i  = 1'b0;
    icache_miss_i    = 1'b0;
    fe_queue_ready_i = 1'b0;
    fill_table();
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // idle in boot, then start at the boot pc
    err_start = errors + flow_errors;
    repeat (10) drive_cycle(1'b0, '0);
    drive_cycle(1'b1, make_cmd(cmd_reset, boot_pc, 0, 0));
    while (n_msgs == 0)
      drive_cycle(1'b0, '0);
    end_test("boot", err_start);

    err_start = errors + flow_errors;
    gap       = 40 + rnd(41);
    for (int cyc = 0; cyc < run_cycles; cyc++)
    begin
      if (gap == 0)
      begin
        drive_cycle(1'b1, random_redirect());
        gap = 40 + rnd(41);
      end
      else
      begin
        drive_cycle(1'b0, '0);
        gap--;
      end
    end
    end_test("random", err_start);

    // 0x180 -> 0x300 and 0x300 -> 0x180 through the btb
    err_start = errors + flow_errors;
    btb_start = n_btb_pred;
    drive_cycle(1'b1, make_cmd(cmd_redirect, 32'h300, 'h20, 'h01));
    repeat (5) drive_cycle(1'b0, '0);
    drive_cycle(1'b1, make_cmd(cmd_redirect, 32'h180, 'h00, 'h03));
    repeat (100) drive_cycle(1'b0, '0);
    end_test("btb_loop", err_start);
    assert (n_btb_pred - btb_start >= 10)
    else
    begin
      $display("ERROR: the btb loop produced only %0d predicted targets",
               n_btb_pred - btb_start);
      flow_errors++;
    end

    err_start = errors + flow_errors;
    exc_start = n_exc;
    drive_cycle(1'b1, make_cmd(cmd_redirect, 32'h202, 5, 2));
    repeat (40) drive_cycle(1'b0, '0);
    end_test("misaligned", err_start);
    assert (n_exc == exc_start + 1 && mode == m_halt)
    else
    begin
      $display("ERROR: the misaligned redirect did not give exactly one exception");
      flow_errors++;
    end

    $display("checks %0d, messages %0d, btb %0d, taken %0d, exceptions %0d, misses %0d, errors %0d",
             n_checks, n_msgs, n_btb_pred, n_taken, n_exc, n_miss, errors + flow_errors);
    if (errors + flow_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: vlog.f
src/fe_pkg.sv
src/fe_instr_scan.sv
src/fe_btb.sv
src/fe_pc_gen.sv
src/fe_top.sv
sim/fe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the fetch front end testbench with Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module fe_tb -f vlog.f -o fe_tb_sim

./obj_dir/fe_tb_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
